// ==== common/compositor_pkg.sv ====
`default_nettype none

package compositor_pkg;

    // ----------------------------------------
    // raster geometry
    // ----------------------------------------
    localparam int RES_X   = 64;
    localparam int RES_Y   = 48;
    localparam int H_TOTAL = 80;
    localparam int V_TOTAL = 52;

    // foreground coordinate bit that flips the checker color.
    localparam int CHECKER_BIT = 3;

    // ----------------------------------------
    // data types
    // ----------------------------------------
    typedef logic [10:0]        coord_t;
    typedef logic signed [11:0] offset_t;
    typedef logic [11:0]        pixel_t;
    typedef logic [15:0]        frame_cnt_t;

    typedef logic [4:0]  axi_addr_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [3:0]  axi_strb_t;
    typedef logic [1:0]  axi_resp_t;

    localparam axi_resp_t RESP_OKAY = 2'b00;

    // register byte addresses.
    localparam axi_addr_t ADDR_CTRL   = 5'h00;
    localparam axi_addr_t ADDR_OFFSET = 5'h04;
    localparam axi_addr_t ADDR_BG     = 5'h08;
    localparam axi_addr_t ADDR_FG     = 5'h0C;
    localparam axi_addr_t ADDR_STATUS = 5'h10;

    typedef enum logic [1:0] {
        SCALE_FULL    = 2'b00,
        SCALE_HALF    = 2'b01,
        SCALE_QUARTER = 2'b10,
        SCALE_OFF     = 2'b11
    } scale_t;

    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,
        ST_RUN  = 2'b01,
        ST_STOP = 2'b10
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== rtl/video_timing.sv ====
`timescale 1ns/100ps
`default_nettype none

module video_timing (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   run,
    output compositor_pkg::coord_t pos_x,
    output compositor_pkg::coord_t pos_y,
    output logic                   active,
    output logic                   frame_end
);
    import compositor_pkg::*;

    coord_t h_cnt;
    coord_t v_cnt;
    logic   h_last;
    logic   v_last;

    assign h_last = (h_cnt == coord_t'(H_TOTAL - 1));
    assign v_last = (v_cnt == coord_t'(V_TOTAL - 1));

    // held at 0,0 while stopped so each run starts clean.
    always_ff @(posedge clk) begin
        if (rst || !run) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
            if (v_last) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign pos_x = h_cnt;
    assign pos_y = v_cnt;

    assign active = run
                 && (h_cnt < coord_t'(RES_X))
                 && (v_cnt < coord_t'(RES_Y));

    // last count of the frame, blanking included.
    assign frame_end = run && h_last && v_last;

endmodule

`default_nettype wire

// ==== rtl/frame_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module frame_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       enable,
    input  logic                       frame_end,
    output logic                       run,
    output logic                       commit,
    output logic                       running,
    output compositor_pkg::frame_cnt_t frame_count
);
    import compositor_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    logic        count_en;

    always_comb begin
        state_nxt = state;
        commit    = 1'b0;
        count_en  = 1'b0;
        case (state)
            ST_IDLE: begin
                if (enable) begin
                    commit    = 1'b1;
                    state_nxt = ST_RUN;
                end
            end
            ST_RUN: begin
                if (frame_end) begin
                    count_en = 1'b1;
                    if (enable) begin
                        commit = 1'b1;
                    end else begin
                        state_nxt = ST_IDLE;
                    end
                end else if (!enable) begin
                    state_nxt = ST_STOP;
                end
            end
            // stop request, wait out the current frame.
            ST_STOP: begin
                if (frame_end) begin
                    count_en  = 1'b1;
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            frame_count <= '0;
        end else begin
            state <= state_nxt;
            if (count_en) begin
                frame_count <= frame_count + 1'b1;
            end
        end
    end

    assign running = (state != ST_IDLE);
    assign run     = running;

endmodule

`default_nettype wire

// ==== rtl/fg_scale.sv ====
`timescale 1ns/100ps
`default_nettype none

module fg_scale (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    commit,
    input  compositor_pkg::scale_t  scale_cfg,
    input  compositor_pkg::offset_t offset_x_cfg,
    input  compositor_pkg::offset_t offset_y_cfg,
    input  compositor_pkg::coord_t  pos_x,
    input  compositor_pkg::coord_t  pos_y,
    input  logic                    active,
    input  logic                    frame_first,
    output compositor_pkg::offset_t fg_x,
    output compositor_pkg::offset_t fg_y,
    output logic                    fg_active,
    output logic                    pix_valid,
    output logic                    pix_first
);
    import compositor_pkg::*;

    scale_t             scale_r;
    offset_t            off_x_r;
    offset_t            off_y_r;
    logic signed [12:0] dx;
    logic signed [12:0] dy;
    logic signed [14:0] sx;
    logic signed [14:0] sy;
    logic               in_range;

    // shadow config, only changes between frames.
    always_ff @(posedge clk) begin
        if (rst) begin
            scale_r <= SCALE_FULL;
            off_x_r <= '0;
            off_y_r <= '0;
        end else if (commit) begin
            scale_r <= scale_cfg;
            off_x_r <= offset_x_cfg;
            off_y_r <= offset_y_cfg;
        end
    end

    always_comb begin
        dx = $signed({2'b00, pos_x}) - 13'(off_x_r);
        dy = $signed({2'b00, pos_y}) - 13'(off_y_r);
        case (scale_r)
            SCALE_FULL: begin
                sx = 15'(dx);
                sy = 15'(dy);
            end
            SCALE_HALF: begin
                sx = 15'(dx) <<< 1;
                sy = 15'(dy) <<< 1;
            end
            SCALE_QUARTER: begin
                sx = 15'(dx) <<< 2;
                sy = 15'(dy) <<< 2;
            end
            default: begin
                sx = '0;
                sy = '0;
            end
        endcase
        // strict upper bound on both axes.
        in_range = (scale_r != SCALE_OFF) && !dx[12] && !dy[12]
                && (sx < RES_X) && (sy < RES_Y);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fg_active <= 1'b0;
            pix_valid <= 1'b0;
            pix_first <= 1'b0;
        end else begin
            fg_active <= active && in_range;
            pix_valid <= active;
            pix_first <= frame_first;
        end
    end

    always_ff @(posedge clk) begin
        fg_x <= offset_t'(sx);
        fg_y <= offset_t'(sy);
    end

endmodule

`default_nettype wire

// ==== rtl/fg_blend.sv ====
`timescale 1ns/100ps
`default_nettype none

module fg_blend (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    commit,
    input  compositor_pkg::pixel_t  bg_cfg,
    input  compositor_pkg::pixel_t  fg_a_cfg,
    input  compositor_pkg::pixel_t  fg_b_cfg,
    input  compositor_pkg::offset_t fg_x,
    input  compositor_pkg::offset_t fg_y,
    input  logic                    fg_active,
    input  logic                    pix_valid,
    input  logic                    pix_first,
    output compositor_pkg::pixel_t  pixel_data,
    output logic                    pixel_valid,
    output logic                    frame_start
);
    import compositor_pkg::*;

    pixel_t bg_r;
    pixel_t fg_a_r;
    pixel_t fg_b_r;
    logic   pick_a;
    pixel_t color;

    always_ff @(posedge clk) begin
        if (rst) begin
            bg_r   <= '0;
            fg_a_r <= '0;
            fg_b_r <= '0;
        end else if (commit) begin
            bg_r   <= bg_cfg;
            fg_a_r <= fg_a_cfg;
            fg_b_r <= fg_b_cfg;
        end
    end

    // checker cell parity.
    assign pick_a = (fg_x[CHECKER_BIT] == fg_y[CHECKER_BIT]);

    always_comb begin
        if (!fg_active) begin
            color = bg_r;
        end else if (pick_a) begin
            color = fg_a_r;
        end else begin
            color = fg_b_r;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pixel_valid <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            pixel_valid <= pix_valid;
            frame_start <= pix_first;
        end
    end

    always_ff @(posedge clk) begin
        pixel_data <= color;
    end

endmodule

`default_nettype wire

// ==== rtl/compositor_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module compositor_regs (
    input  logic                       clk,
    input  logic                       rst,
    input  compositor_pkg::axi_addr_t  awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  compositor_pkg::axi_data_t  wdata,
    input  compositor_pkg::axi_strb_t  wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    output compositor_pkg::axi_resp_t  bresp,
    output logic                       bvalid,
    input  logic                       bready,
    input  compositor_pkg::axi_addr_t  araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output compositor_pkg::axi_data_t  rdata,
    output compositor_pkg::axi_resp_t  rresp,
    output logic                       rvalid,
    input  logic                       rready,
    output logic                       enable,
    output compositor_pkg::scale_t     scale_cfg,
    output compositor_pkg::offset_t    offset_x_cfg,
    output compositor_pkg::offset_t    offset_y_cfg,
    output compositor_pkg::pixel_t     bg_cfg,
    output compositor_pkg::pixel_t     fg_a_cfg,
    output compositor_pkg::pixel_t     fg_b_cfg,
    input  compositor_pkg::frame_cnt_t frame_count,
    input  logic                       running
);
    import compositor_pkg::*;

    logic      wr_accept;
    logic      rd_accept;
    logic      wr_en;
    logic      rd_en;
    axi_addr_t wr_word;
    axi_addr_t rd_word;
    axi_data_t ctrl_word;
    axi_data_t offset_word;
    axi_data_t bg_word;
    axi_data_t fg_word;
    axi_data_t status_word;
    axi_data_t wr_old;
    axi_data_t wr_new;
    axi_data_t rd_val;

    function automatic axi_data_t merge_bytes(axi_data_t old_val, axi_data_t new_val,
                                              axi_strb_t strb);
        axi_data_t res;
        res = old_val;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return res;
    endfunction

    // ----------------------------------------
    // register views
    // ----------------------------------------
    assign ctrl_word   = {29'd0, scale_cfg, enable};
    assign offset_word = {4'd0, offset_y_cfg, 4'd0, offset_x_cfg};
    assign bg_word     = {20'd0, bg_cfg};
    assign fg_word     = {4'd0, fg_b_cfg, 4'd0, fg_a_cfg};
    assign status_word = {15'd0, running, frame_count};

    assign wr_word = {awaddr[4:2], 2'b00};
    assign rd_word = {araddr[4:2], 2'b00};

    always_comb begin
        case (wr_word)
            ADDR_CTRL:   wr_old = ctrl_word;
            ADDR_OFFSET: wr_old = offset_word;
            ADDR_BG:     wr_old = bg_word;
            ADDR_FG:     wr_old = fg_word;
            default:     wr_old = '0;
        endcase
        case (rd_word)
            ADDR_CTRL:   rd_val = ctrl_word;
            ADDR_OFFSET: rd_val = offset_word;
            ADDR_BG:     rd_val = bg_word;
            ADDR_FG:     rd_val = fg_word;
            ADDR_STATUS: rd_val = status_word;
            default:     rd_val = '0;
        endcase
    end

    assign wr_new = merge_bytes(wr_old, wdata, wstrb);

    // ----------------------------------------
    // handshakes
    // ----------------------------------------
    assign wr_accept = awvalid && wvalid && !bvalid && !awready;
    assign rd_accept = arvalid && !rvalid && !arready;
    assign wr_en     = awready && awvalid && wvalid;
    assign rd_en     = arready && arvalid;

    always_ff @(posedge clk) begin
        if (rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            awready <= wr_accept;
            wready  <= wr_accept;
            arready <= rd_accept;
            if (wr_en) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_en) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata <= rd_val;
        end
    end

    assign bresp = RESP_OKAY;
    assign rresp = RESP_OKAY;

    // status and unmapped words fall through.
    always_ff @(posedge clk) begin
        if (rst) begin
            enable       <= 1'b0;
            scale_cfg    <= SCALE_FULL;
            offset_x_cfg <= '0;
            offset_y_cfg <= '0;
            bg_cfg       <= '0;
            fg_a_cfg     <= '0;
            fg_b_cfg     <= '0;
        end else if (wr_en) begin
            case (wr_word)
                ADDR_CTRL: begin
                    enable    <= wr_new[0];
                    scale_cfg <= scale_t'(wr_new[2:1]);
                end
                ADDR_OFFSET: begin
                    offset_x_cfg <= wr_new[11:0];
                    offset_y_cfg <= wr_new[27:16];
                end
                ADDR_BG: bg_cfg <= wr_new[11:0];
                ADDR_FG: begin
                    fg_a_cfg <= wr_new[11:0];
                    fg_b_cfg <= wr_new[27:16];
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/video_compositor.sv ====
`timescale 1ns/100ps
`default_nettype none

module video_compositor (
    input  logic                      clk,
    input  logic                      rst,
    input  compositor_pkg::axi_addr_t awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  compositor_pkg::axi_data_t wdata,
    input  compositor_pkg::axi_strb_t wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output compositor_pkg::axi_resp_t bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  compositor_pkg::axi_addr_t araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output compositor_pkg::axi_data_t rdata,
    output compositor_pkg::axi_resp_t rresp,
    output logic                      rvalid,
    input  logic                      rready,
    output compositor_pkg::pixel_t    pixel_data,
    output logic                      pixel_valid,
    output logic                      frame_start
);
    import compositor_pkg::*;

    logic       enable;
    scale_t     scale_cfg;
    offset_t    offset_x_cfg;
    offset_t    offset_y_cfg;
    pixel_t     bg_cfg;
    pixel_t     fg_a_cfg;
    pixel_t     fg_b_cfg;
    frame_cnt_t frame_count;
    logic       running;
    logic       run;
    logic       commit;
    logic       frame_end;
    coord_t     pos_x;
    coord_t     pos_y;
    logic       active;
    logic       frame_first;
    offset_t    fg_x;
    offset_t    fg_y;
    logic       fg_active;
    logic       pix_valid;
    logic       pix_first;

    // first visible pixel of the frame.
    assign frame_first = active && (pos_x == '0) && (pos_y == '0);

    compositor_regs regs_i (
        .clk, .rst,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .enable, .scale_cfg, .offset_x_cfg, .offset_y_cfg,
        .bg_cfg, .fg_a_cfg, .fg_b_cfg,
        .frame_count, .running
    );

    frame_ctrl ctrl_i (
        .clk, .rst, .enable, .frame_end,
        .run, .commit, .running, .frame_count
    );

    video_timing timing_i (
        .clk, .rst, .run, .pos_x, .pos_y, .active, .frame_end
    );

    fg_scale scale_i (
        .clk, .rst, .commit, .scale_cfg, .offset_x_cfg, .offset_y_cfg,
        .pos_x, .pos_y, .active, .frame_first,
        .fg_x, .fg_y, .fg_active, .pix_valid, .pix_first
    );

    fg_blend blend_i (
        .clk, .rst, .commit, .bg_cfg, .fg_a_cfg, .fg_b_cfg,
        .fg_x, .fg_y, .fg_active, .pix_valid, .pix_first,
        .pixel_data, .pixel_valid, .frame_start
    );

endmodule

`default_nettype wire

// ==== tests/video_compositor_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module video_compositor_chk (
    input logic                      clk,
    input logic                      rst,
    input logic                      bvalid,
    input logic                      bready,
    input logic                      rvalid,
    input logic                      rready,
    input compositor_pkg::axi_data_t rdata,
    input logic                      pixel_valid,
    input logic                      frame_start,
    input logic                      running
);
    int fail_count = 0;

    // responses wait for the master.
    bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid)
        else begin
            $error("bvalid dropped before bready");
            fail_count++;
        end

    rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else begin
            $error("rvalid or rdata changed before rready");
            fail_count++;
        end

    // ----------------------------------------
    // pixel stream
    // ----------------------------------------
    valid_needs_run: assert property (@(posedge clk) disable iff (rst)
        pixel_valid |-> running)
        else begin
            $error("pixel_valid high while stopped");
            fail_count++;
        end

    start_with_valid: assert property (@(posedge clk) disable iff (rst)
        frame_start |-> pixel_valid)
        else begin
            $error("frame_start without pixel_valid");
            fail_count++;
        end

endmodule

bind video_compositor video_compositor_chk chk_i (
    .clk, .rst, .bvalid, .bready, .rvalid, .rready, .rdata,
    .pixel_valid, .frame_start, .running
);

`default_nettype wire

// ==== tests/video_compositor_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module video_compositor_tb;
    import compositor_pkg::*;

    localparam int          NUM_PIX        = RES_X * RES_Y;
    localparam int          FRAME_CYCLES   = H_TOTAL * V_TOTAL;
    localparam int          TIMEOUT_CYCLES = 10 * FRAME_CYCLES + 3400;
    localparam int          MID_FRAME      = 1000;
    localparam logic [31:0] SEED           = 32'h8af4c602;

    logic      clk = 1'b0;
    logic      rst;
    axi_addr_t awaddr;
    logic      awvalid;
    logic      awready;
    axi_data_t wdata;
    axi_strb_t wstrb;
    logic      wvalid;
    logic      wready;
    axi_resp_t bresp;
    logic      bvalid;
    logic      bready;
    axi_addr_t araddr;
    logic      arvalid;
    logic      arready;
    axi_data_t rdata;
    axi_resp_t rresp;
    logic      rvalid;
    logic      rready;
    pixel_t    pixel_data;
    logic      pixel_valid;
    logic      frame_start;

    // register model and the config of the frame on screen.
    axi_data_t mirror [0:3];
    axi_data_t snap [0:3];
    int        frames_seen = 0;
    int        pix_count = 0;
    int        cycles = 0;

    video_compositor dut_i (.*);

    always #5 clk = ~clk;

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic value_error(string what);
        abort_run($sformatf("** Error [%0t] %s", $time, what));
    endtask

    function automatic axi_data_t reg_mask(int idx);
        case (idx)
            0:       return 32'h0000_0007;
            1:       return 32'h0FFF_0FFF;
            2:       return 32'h0000_0FFF;
            default: return 32'h0FFF_0FFF;
        endcase
    endfunction

    // distance from the offset, scaled up, then a checker on one bit.
    function automatic pixel_t expected_pixel(int x, int y, axi_data_t ctrl_w,
                                              axi_data_t off_w, axi_data_t bg_w,
                                              axi_data_t fg_w);
        offset_t ox;
        offset_t oy;
        int      shift;
        int      sx;
        int      sy;
        ox = off_w[11:0];
        oy = off_w[27:16];
        case (scale_t'(ctrl_w[2:1]))
            SCALE_FULL:    shift = 0;
            SCALE_HALF:    shift = 1;
            SCALE_QUARTER: shift = 2;
            default:       return bg_w[11:0];
        endcase
        sx = x - int'(ox);
        sy = y - int'(oy);
        if (sx < 0 || sy < 0) begin
            return bg_w[11:0];
        end
        sx = sx << shift;
        sy = sy << shift;
        if (sx >= RES_X || sy >= RES_Y) begin
            return bg_w[11:0];
        end
        if (((sx >> CHECKER_BIT) & 1) == ((sy >> CHECKER_BIT) & 1)) begin
            return fg_w[11:0];
        end
        return fg_w[27:16];
    endfunction

    function automatic int rand_offset();
        return int'($urandom_range(127, 0)) - 48;
    endfunction

    // ----------------------------------------
    // AXI4-Lite master
    // ----------------------------------------
    task automatic axi_write(axi_addr_t addr, axi_data_t data, axi_strb_t strb);
        int idx;
        int stall;
        stall = int'($urandom_range(3, 0));
        @(posedge clk);
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= strb;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        do @(posedge clk); while (!awready);
        assert (wready) else abort_run("wready did not rise together with awready");
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        do @(posedge clk); while (!bvalid);
        assert (bresp === RESP_OKAY)
        else value_error($sformatf("write 0x%02h: bresp %b, expected OKAY", addr, bresp));
        // byte merge, then only the implemented bits.
        idx = int'(addr[4:2]);
        if (idx < 4) begin
            for (int i = 0; i < 4; i++) begin
                if (strb[i]) begin
                    mirror[idx][8*i +: 8] = data[8*i +: 8];
                end
            end
            mirror[idx] &= reg_mask(idx);
        end
        // response held back for a few cycles.
        repeat (stall) @(posedge clk);
        bready <= 1'b1;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic axi_read(axi_addr_t addr, output axi_data_t data);
        int stall;
        stall = int'($urandom_range(3, 0));
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        do @(posedge clk); while (!arready);
        arvalid <= 1'b0;
        do @(posedge clk); while (!rvalid);
        assert (rresp === RESP_OKAY)
        else value_error($sformatf("read 0x%02h: rresp %b, expected OKAY", addr, rresp));
        repeat (stall) @(posedge clk);
        data = rdata;
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic check_read(axi_addr_t addr, axi_data_t expected);
        axi_data_t got;
        axi_read(addr, got);
        assert (got === expected)
        else value_error($sformatf("read 0x%02h: got %h, expected %h", addr, got, expected));
    endtask

    task automatic wait_frames(int count);
        while (frames_seen < count) begin
            @(posedge clk);
        end
    endtask

    // new scale and offset, written well inside the given frame.
    task automatic reconfigure(int frame_no, scale_t scale, int off_x, int off_y);
        wait_frames(frame_no);
        repeat (MID_FRAME) @(posedge clk);
        axi_write(ADDR_OFFSET, {4'd0, 12'(off_y), 4'd0, 12'(off_x)}, 4'hF);
        axi_write(ADDR_CTRL, {29'd0, scale, 1'b1}, 4'hF);
    endtask

    // ----------------------------------------
    // pixel comparison
    // ----------------------------------------
    always @(posedge clk) begin : compare_pixels
        int     idx;
        pixel_t expected;
        if (!rst && pixel_valid) begin
            if (frame_start) begin
                assert (frames_seen == 0 || pix_count == NUM_PIX)
                else value_error($sformatf("frame %0d had %0d pixels", frames_seen, pix_count));
                // config committed at this boundary.
                for (int i = 0; i < 4; i++) begin
                    snap[i] = mirror[i];
                end
                idx = 0;
                frames_seen <= frames_seen + 1;
            end else begin
                idx = pix_count;
            end
            assert (frames_seen > 0 || frame_start)
            else abort_run("pixel_valid arrived before the first frame_start");
            assert (idx < NUM_PIX)
            else value_error($sformatf("frame %0d has too many pixels", frames_seen));
            expected = expected_pixel(idx % RES_X, idx / RES_X,
                                      snap[0], snap[1], snap[2], snap[3]);
            assert (pixel_data === expected)
            else value_error($sformatf("pixel (%0d,%0d): got %h, expected %h",
                                       idx % RES_X, idx / RES_X, pixel_data, expected));
            pix_count <= idx + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout: run did not end within %0d cycles", cycles));
        end else if (dut_i.chk_i.fail_count != 0) begin
            abort_run("a bound protocol assertion failed");
        end
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    initial begin
        axi_data_t rd;
        axi_data_t wr;
        void'($urandom(SEED));
        rst     <= 1'b1;
        awaddr  <= '0;
        awvalid <= 1'b0;
        wdata   <= '0;
        wstrb   <= '0;
        wvalid  <= 1'b0;
        bready  <= 1'b0;
        araddr  <= '0;
        arvalid <= 1'b0;
        rready  <= 1'b0;
        for (int i = 0; i < 4; i++) begin
            mirror[i] = '0;
            snap[i]   = '0;
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // idle after reset, then register readback.
        repeat (2 * H_TOTAL) begin
            @(posedge clk);
            assert (!pixel_valid) else abort_run("pixel_valid went high while disabled");
        end
        check_read(ADDR_STATUS, '0);
        for (int a = 0; a < 4; a++) begin
            wr = $urandom;
            if (a == 0) begin
                wr[0] = 1'b0;
            end
            axi_write(axi_addr_t'(4 * a), wr, 4'hF);
            check_read(axi_addr_t'(4 * a), mirror[a]);
        end
        axi_write(ADDR_FG, $urandom, 4'b0101);
        check_read(ADDR_FG, mirror[3]);
        axi_write(ADDR_STATUS, $urandom, 4'hF);
        check_read(ADDR_STATUS, '0);
        for (int a = 5; a < 8; a++) begin
            axi_write(axi_addr_t'(4 * a), $urandom, 4'hF);
            check_read(axi_addr_t'(4 * a), '0);
        end

        // full scale at 0,0.
        axi_write(ADDR_OFFSET, '0, 4'hF);
        axi_write(ADDR_BG, {20'd0, pixel_t'($urandom)}, 4'hF);
        axi_write(ADDR_FG, {4'd0, pixel_t'($urandom), 4'd0, pixel_t'($urandom)}, 4'hF);
        axi_write(ADDR_CTRL, {29'd0, SCALE_FULL, 1'b1}, 4'hF);
        wait_frames(1);
        repeat (MID_FRAME) @(posedge clk);
        check_read(ADDR_STATUS, 32'h0001_0000);

        // mid-frame color and scale changes.
        axi_write(ADDR_BG, {20'd0, pixel_t'($urandom)}, 4'hF);
        axi_write(ADDR_FG, {4'd0, pixel_t'($urandom), 4'd0, pixel_t'($urandom)}, 4'hF);
        reconfigure(1, SCALE_HALF, rand_offset(), rand_offset());
        reconfigure(2, SCALE_QUARTER, rand_offset(), rand_offset());
        reconfigure(3, SCALE_HALF, -1 - int'($urandom_range(31, 0)),
                    -1 - int'($urandom_range(31, 0)));
        reconfigure(4, SCALE_QUARTER, RES_X + int'($urandom_range(31, 0)), rand_offset());
        reconfigure(5, SCALE_OFF, rand_offset(), rand_offset());
        axi_write(ADDR_BG, {20'd0, pixel_t'($urandom)}, 4'hF);

        // stop request, the frame still completes.
        wait_frames(6);
        repeat (MID_FRAME) @(posedge clk);
        axi_write(ADDR_CTRL, {29'd0, SCALE_OFF, 1'b0}, 4'hF);
        do begin
            axi_read(ADDR_STATUS, rd);
        end while (rd[16]);
        assert (pix_count == NUM_PIX)
        else value_error($sformatf("last frame stopped after %0d pixels", pix_count));
        assert (frames_seen == 6)
        else value_error($sformatf("saw %0d frames, expected 6", frames_seen));
        assert (rd[15:0] == 16'(frames_seen))
        else value_error($sformatf("frame count %0d, frame_start seen %0d",
                                   rd[15:0], frames_seen));
        repeat (2 * H_TOTAL) begin
            @(posedge clk);
            assert (!pixel_valid) else abort_run("pixel_valid went high after the stop");
        end

        if (dut_i.chk_i.fail_count == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            abort_run("protocol assertions failed in video_compositor_chk");
        end
    end

endmodule

`default_nettype wire

// ==== video_compositor.f ====
common/compositor_pkg.sv
rtl/video_timing.sv
rtl/frame_ctrl.sv
rtl/fg_scale.sv
rtl/fg_blend.sv
rtl/compositor_regs.sv
rtl/video_compositor.sv
tests/video_compositor_chk.sv
tests/video_compositor_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FILELIST   ?= video_compositor.f
TB_TOP     ?= video_compositor_tb
RTL_TOP    ?= video_compositor
BUILD_DIR  ?= obj_dir
SIM_BIN    ?= sim_top
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall
RTL_SRCS   ?= common/compositor_pkg.sv rtl/video_timing.sv rtl/frame_ctrl.sv \
              rtl/fg_scale.sv rtl/fg_blend.sv rtl/compositor_regs.sv \
              rtl/video_compositor.sv

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -o $(SIM_BIN) -f $(FILELIST)

sim: build
	-./$(BUILD_DIR)/$(SIM_BIN) > $(LOG) 2>&1
	cat $(LOG)
	grep -qx "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
